// File: Bender.yml
package:
  name: soc_dbus

sources:
  - rtl/soc_pkg.sv
  - rtl/dbus.sv
  - rtl/bytes_conv.sv
  - rtl/word_ram.sv
  - rtl/gpio_top.sv
  - rtl/ticker.sv
  - rtl/soc_dbus_top.sv
  - target: test
    files:
      - bench/tb_soc_dbus.sv

// File: bench/tb_soc_dbus.sv
`timescale 1ns/10ps

module tb_soc_dbus import soc_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int SEED        = 32'hbe95;
    localparam int RAM_WORDS_N = 32;
    localparam int PARTIAL_N   = 16;
    localparam int GPIO_N      = 6;
    localparam int TICK_GAP    = 25;
    localparam int IRQ_LEAD    = 12;

    localparam bus_addr_t GPIO_OUT_ADDR   = {REGION_GPIO, 28'h000_0000};
    localparam bus_addr_t GPIO_IN_ADDR    = {REGION_GPIO, 28'h000_0004};
    localparam bus_addr_t TICK_COUNT_ADDR = {REGION_TICKER, 28'h000_0000};
    localparam bus_addr_t TICK_CMP_ADDR   = {REGION_TICKER, 28'h000_0004};
    localparam bus_addr_t UNMAPPED_ADDR   = {4'h4, 28'h000_0000};

    // rough cycle cost of each test, summed for the watchdog.
    localparam int BUDGET_CYCLES = 10 + RAM_WORDS_N * 6 + PARTIAL_N * 8
                                 + GPIO_N * 6 + 12 + TICK_GAP + 8 + IRQ_LEAD + 16 + 20;

    logic      clk;
    logic      reset_i;
    bus_addr_t dbus_address_i;
    byte_en_t  dbus_byteenable_i;
    logic      dbus_read_i;
    logic      dbus_write_i;
    bus_data_t dbus_wrdata_i;
    bus_data_t dbus_rddata_o;
    logic      dbus_stall_o;
    bus_data_t gpio_i;
    bus_data_t gpio_o;
    logic      ticker_irq_o;

    int         errors = 0;
    time        accept_time;                        // edge of the last accepted request.
    logic [7:0] ram_model [int];                    // keyed by byte address.
    bus_data_t  gpio_model;
    int         ram_idx [RAM_WORDS_N];

    soc_dbus_top DUT (
        .clk               (clk),
        .reset_i           (reset_i),
        .dbus_address_i    (dbus_address_i),
        .dbus_byteenable_i (dbus_byteenable_i),
        .dbus_read_i       (dbus_read_i),
        .dbus_write_i      (dbus_write_i),
        .dbus_wrdata_i     (dbus_wrdata_i),
        .dbus_rddata_o     (dbus_rddata_o),
        .dbus_stall_o      (dbus_stall_o),
        .gpio_i            (gpio_i),
        .gpio_o            (gpio_o),
        .ticker_irq_o      (ticker_irq_o)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    endtask

    function automatic bus_addr_t ram_word_addr(input int word_idx);
        bus_addr_t a;
        a = '0;
        a[31:28] = REGION_RAM;
        a[RAM_AW+1:2] = word_idx;
        return a;
    endfunction

    function automatic void merge_into_model(input int word_idx, input byte_en_t be,
                                             input bus_data_t data);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ram_model[word_idx*4 + i] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic bus_data_t word_from_model(input int word_idx);
        bus_data_t w;
        w = 'x;                                     // unwritten bytes never match.
        for (int i = 0; i < 4; i++) begin
            if (ram_model.exists(word_idx*4 + i)) begin
                w[8*i +: 8] = ram_model[word_idx*4 + i];
            end
        end
        return w;
    endfunction

    // request held while stalled, accepted at the first edge with stall low.
    task automatic bus_write(input bus_addr_t addr, input byte_en_t be, input bus_data_t data,
                             output int stalls);
        stalls = 0;
        @(negedge clk);
        dbus_address_i    = addr;
        dbus_byteenable_i = be;
        dbus_wrdata_i     = data;
        dbus_write_i      = 1'b1;
        #1;
        while (dbus_stall_o) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        accept_time = $time;
        @(negedge clk);
        dbus_write_i = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output int stalls);
        stalls = 0;
        @(negedge clk);
        dbus_address_i    = addr;
        dbus_byteenable_i = 4'hf;
        dbus_read_i       = 1'b1;
        #1;
        while (dbus_stall_o) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        accept_time = $time;
        @(negedge clk);
        data        = dbus_rddata_o;                // valid from the edge after acceptance.
        dbus_read_i = 1'b0;
    endtask

    task automatic check_reset_state();
        #1;
        if (dbus_stall_o !== 1'b0) begin
            report_mismatch("check_reset_state stall", 32'd0, dbus_stall_o);
        end
        if (ticker_irq_o !== 1'b0) begin
            report_mismatch("check_reset_state irq", 32'd0, ticker_irq_o);
        end
        if (gpio_o !== '0) begin
            report_mismatch("check_reset_state gpio_o", 32'd0, gpio_o);
        end
    endtask

    task automatic ram_word_roundtrip();
        bus_data_t data;
        bus_data_t got;
        int        stalls;
        for (int k = 0; k < RAM_WORDS_N; k++) begin
            ram_idx[k] = $urandom_range(0, 2**RAM_AW - 1);
            data = $urandom;
            bus_write(ram_word_addr(ram_idx[k]), 4'hf, data, stalls);
            merge_into_model(ram_idx[k], 4'hf, data);
            if (stalls != 0) begin
                report_mismatch("ram_word_roundtrip write stall", 32'd0, stalls);
            end
        end
        for (int k = 0; k < RAM_WORDS_N; k++) begin
            bus_read(ram_word_addr(ram_idx[k]), got, stalls);
            if (got !== word_from_model(ram_idx[k])) begin
                report_mismatch("ram_word_roundtrip data", word_from_model(ram_idx[k]), got);
            end
            if (stalls != 0) begin
                report_mismatch("ram_word_roundtrip read stall", 32'd0, stalls);
            end
        end
    endtask

    task automatic ram_partial_merge();
        int        idx;
        byte_en_t  be;
        bus_data_t data;
        bus_data_t got;
        int        stalls;
        for (int n = 0; n < PARTIAL_N; n++) begin
            idx  = ram_idx[$urandom_range(0, RAM_WORDS_N - 1)];
            be   = $urandom_range(0, 14);           // anything but a full word.
            data = $urandom;
            bus_write(ram_word_addr(idx), be, data, stalls);
            merge_into_model(idx, be, data);
            if (stalls != 2) begin
                report_mismatch("ram_partial_merge stall cycles", 32'd2, stalls);
            end
            bus_read(ram_word_addr(idx), got, stalls);
            if (got !== word_from_model(idx)) begin
                report_mismatch("ram_partial_merge data", word_from_model(idx), got);
            end
        end
    endtask

    task automatic gpio_out_and_in();
        byte_en_t  be;
        bus_data_t data;
        bus_data_t got;
        bus_data_t pins;
        int        stalls;
        for (int n = 0; n < GPIO_N; n++) begin
            be   = $urandom_range(1, 15);
            data = $urandom;
            bus_write(GPIO_OUT_ADDR, be, data, stalls);
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    gpio_model[8*i +: 8] = data[8*i +: 8];
                end
            end
            if (gpio_o !== gpio_model) begin
                report_mismatch("gpio_out_and_in pins", gpio_model, gpio_o);
            end
            bus_read(GPIO_OUT_ADDR, got, stalls);
            if (got !== gpio_model) begin
                report_mismatch("gpio_out_and_in readback", gpio_model, got);
            end
        end
        pins = $urandom;
        @(negedge clk);
        gpio_i = pins;
        @(negedge clk);                             // read lands on the third edge.
        bus_read(GPIO_IN_ADDR, got, stalls);
        if (got !== pins) begin
            report_mismatch("gpio_out_and_in input", pins, got);
        end
        bus_read(GPIO_IN_ADDR + 4, got, stalls);
        if (got !== '0) begin
            report_mismatch("gpio_out_and_in unused offset", 32'd0, got);
        end
    endtask

    task automatic ticker_count_step();
        bus_data_t c1;
        bus_data_t c2;
        bus_data_t diff;
        time       t1;
        int        stalls;
        bus_read(TICK_COUNT_ADDR, c1, stalls);
        t1 = accept_time;
        repeat (TICK_GAP - 2) @(negedge clk);
        bus_read(TICK_COUNT_ADDR, c2, stalls);
        if (accept_time - t1 != TICK_GAP * CLK_PERIOD) begin
            errors++;
            $display("ticker_count_step: the two reads were not accepted %0d cycles apart",
                     TICK_GAP);
        end
        diff = c2 - c1;
        if (diff !== TICK_GAP) begin
            report_mismatch("ticker_count_step difference", TICK_GAP, diff);
        end
    endtask

    task automatic ticker_compare_irq();
        bus_data_t c0;
        time       t0;
        int        j;
        logic      exp_irq;
        int        stalls;
        bus_read(TICK_COUNT_ADDR, c0, stalls);
        t0 = accept_time;
        bus_write(TICK_CMP_ADDR, 4'hf, c0 + IRQ_LEAD, stalls);
        // the falling edge j cycles after the count read follows count c0 + j.
        do begin
            @(negedge clk);
            j = int'(($time - t0) / CLK_PERIOD);
            exp_irq = (j >= IRQ_LEAD);
            if (ticker_irq_o !== exp_irq) begin
                report_mismatch($sformatf("ticker_compare_irq cycle %0d", j), exp_irq,
                                ticker_irq_o);
            end
        end while (j < IRQ_LEAD + 3);
        bus_write(TICK_CMP_ADDR, 4'hf, 32'd0, stalls);
        if (ticker_irq_o !== 1'b0) begin
            report_mismatch("ticker_compare_irq clear", 32'd0, ticker_irq_o);
        end
    endtask

    task automatic unmapped_region();
        bus_addr_t addr;
        bus_data_t got;
        int        stalls;
        bus_read(UNMAPPED_ADDR + 32'h10, got, stalls);
        if (got !== '0) begin
            report_mismatch("unmapped_region read", 32'd0, got);
        end
        addr = ram_word_addr(ram_idx[0]);
        addr[31:28] = UNMAPPED_ADDR[31:28];         // same low bits as a live ram word.
        bus_write(UNMAPPED_ADDR, 4'hf, $urandom, stalls);
        bus_write(addr, 4'hf, ~word_from_model(ram_idx[0]), stalls);
        if (gpio_o !== gpio_model) begin
            report_mismatch("unmapped_region gpio_o", gpio_model, gpio_o);
        end
        bus_read(ram_word_addr(ram_idx[0]), got, stalls);
        if (got !== word_from_model(ram_idx[0])) begin
            report_mismatch("unmapped_region ram", word_from_model(ram_idx[0]), got);
        end
    endtask

    initial begin
        #(20 * BUDGET_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", 20 * BUDGET_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        reset_i           = 1'b1;
        dbus_address_i    = '0;
        dbus_byteenable_i = '0;
        dbus_read_i       = 1'b0;
        dbus_write_i      = 1'b0;
        dbus_wrdata_i     = '0;
        gpio_i            = '0;
        gpio_model        = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_reset_state();
        ram_word_roundtrip();
        ram_partial_merge();
        gpio_out_and_in();
        ticker_count_step();
        ticker_compare_irq();
        unmapped_region();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/soc_pkg.sv
rtl/dbus.sv
rtl/bytes_conv.sv
rtl/word_ram.sv
rtl/gpio_top.sv
rtl/ticker.sv
rtl/soc_dbus_top.sv
bench/tb_soc_dbus.sv

// File: rtl/bytes_conv.sv
`timescale 1ns/10ps

module bytes_conv import soc_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  ram_addr_t address_i,
    input  byte_en_t  byteenable_i,
    input  bus_data_t wrdata_i,
    input  logic      read_i,
    input  logic      write_i,
    output bus_data_t rddata_o,
    output logic      stall_o,
    output ram_addr_t mem_address_o,
    output bus_data_t mem_wrdata_o,
    output logic      mem_rd_o,
    output logic      mem_wr_o,
    input  bus_data_t mem_rddata_i
);

    conv_state_t state_q;
    conv_state_t state_d;
    logic        partial_wr;
    bus_data_t   merged;

    assign partial_wr = write_i && (byteenable_i != '1);

    assign mem_address_o = address_i;               // held by the master while stalled.
    assign rddata_o      = mem_rddata_i;            // reads always return the whole word.

    // enabled lanes from the master, the rest from the old word
    always_comb begin
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            merged[8*i +: 8] = byteenable_i[i] ? wrdata_i[8*i +: 8]
                                               : mem_rddata_i[8*i +: 8];
        end
    end

    always_comb begin
        state_d      = state_q;
        stall_o      = 1'b0;
        mem_rd_o     = 1'b0;
        mem_wr_o     = 1'b0;
        mem_wrdata_o = wrdata_i;
        case (state_q)
            IDLE: begin
                if (partial_wr) begin
                    stall_o  = 1'b1;
                    mem_rd_o = 1'b1;                // fetch the old word.
                    state_d  = MERGE_READ;
                end else begin
                    mem_rd_o = read_i;
                    mem_wr_o = write_i;
                end
            end
            MERGE_READ: begin
                stall_o      = 1'b1;
                mem_wr_o     = 1'b1;
                mem_wrdata_o = merged;
                state_d      = MERGE_WRITE;
            end
            MERGE_WRITE: begin
                // stall is low, the held write is accepted without a ram access
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    a_held_while_stalled: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |=> $stable({address_i, byteenable_i, wrdata_i, write_i}));

endmodule

// File: rtl/dbus.sv
`timescale 1ns/10ps

module dbus import soc_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  bus_addr_t    master_address_i,
    input  byte_en_t     master_byteenable_i,
    input  logic         master_read_i,
    input  logic         master_write_i,
    input  bus_data_t    master_wrdata_i,
    output bus_data_t    master_rddata_o,
    output logic         master_stall_o,
    output ram_addr_t    ram_address_o,
    output bus_data_t    ram_wrdata_o,
    output byte_en_t     ram_byteenable_o,
    output logic         ram_rd_o,
    output logic         ram_wr_o,
    input  bus_data_t    ram_rddata_i,
    input  logic         ram_stall_i,
    output periph_addr_t gpio_address_o,
    output bus_data_t    gpio_wrdata_o,
    output byte_en_t     gpio_byteenable_o,
    output logic         gpio_rd_o,
    output logic         gpio_wr_o,
    input  bus_data_t    gpio_rddata_i,
    output periph_addr_t ticker_address_o,
    output bus_data_t    ticker_wrdata_o,
    output logic         ticker_rd_o,
    output logic         ticker_wr_o,
    input  bus_data_t    ticker_rddata_i
);

    logic [3:0] region;
    logic       sel_ram;
    logic       sel_gpio;
    logic       sel_ticker;
    logic [2:0] rd_sel_q;                           // {ticker, gpio, ram} of the last read.

    assign region     = master_address_i[31:28];
    assign sel_ram    = (region == REGION_RAM);
    assign sel_gpio   = (region == REGION_GPIO);
    assign sel_ticker = (region == REGION_TICKER);

    assign ram_address_o    = master_address_i[RAM_AW+1:2];
    assign ram_wrdata_o     = master_wrdata_i;
    assign ram_byteenable_o = master_byteenable_i;
    assign ram_rd_o         = master_read_i & sel_ram;
    assign ram_wr_o         = master_write_i & sel_ram;

    assign gpio_address_o    = master_address_i[9:2];
    assign gpio_wrdata_o     = master_wrdata_i;
    assign gpio_byteenable_o = master_byteenable_i;
    assign gpio_rd_o         = master_read_i & sel_gpio;
    assign gpio_wr_o         = master_write_i & sel_gpio;

    assign ticker_address_o = master_address_i[9:2];
    assign ticker_wrdata_o  = master_wrdata_i;
    assign ticker_rd_o      = master_read_i & sel_ticker;
    assign ticker_wr_o      = master_write_i & sel_ticker;

    assign master_stall_o = ram_stall_i;            // only the ram path ever stalls.

    // an unmapped read leaves all select bits low, so it returns zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_sel_q <= '0;
        end else if (master_read_i && !master_stall_o) begin
            rd_sel_q <= {sel_ticker, sel_gpio, sel_ram};
        end
    end

    always_comb begin
        case (rd_sel_q)
            3'b001:  master_rddata_o = ram_rddata_i;
            3'b010:  master_rddata_o = gpio_rddata_i;
            3'b100:  master_rddata_o = ticker_rddata_i;
            default: master_rddata_o = '0;
        endcase
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (reset_i)
        !(master_read_i && master_write_i));

endmodule

// File: rtl/gpio_top.sv
`timescale 1ns/10ps

module gpio_top import soc_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  periph_addr_t address_i,
    input  bus_data_t    wrdata_i,
    input  byte_en_t     byteenable_i,
    input  logic         rd_i,
    input  logic         wr_i,
    output bus_data_t    rddata_o,
    input  bus_data_t    gpio_i,
    output bus_data_t    gpio_o
);

    bus_data_t out_q;
    bus_data_t sync1_q;
    bus_data_t sync2_q;

    assign gpio_o = out_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (wr_i && address_i == 'd0) begin
            for (int i = 0; i < $bits(byte_en_t); i++) begin
                if (byteenable_i[i]) begin
                    out_q[8*i +: 8] <= wrdata_i[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;                          // two stages against metastability.
        sync2_q <= sync1_q;
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            case (address_i)
                'd0:     rddata_o <= out_q;
                'd1:     rddata_o <= sync2_q;
                default: rddata_o <= '0;
            endcase
        end
    end

endmodule

// File: rtl/soc_dbus_top.sv
`timescale 1ns/10ps

module soc_dbus_top import soc_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  bus_addr_t dbus_address_i,
    input  byte_en_t  dbus_byteenable_i,
    input  logic      dbus_read_i,
    input  logic      dbus_write_i,
    input  bus_data_t dbus_wrdata_i,
    output bus_data_t dbus_rddata_o,
    output logic      dbus_stall_o,
    input  bus_data_t gpio_i,
    output bus_data_t gpio_o,
    output logic      ticker_irq_o
);

    ram_addr_t    ram_address;
    bus_data_t    ram_wrdata;
    byte_en_t     ram_byteenable;
    logic         ram_rd;
    logic         ram_wr;
    bus_data_t    ram_rddata;
    logic         ram_stall;

    ram_addr_t    mem_address;
    bus_data_t    mem_wrdata;
    logic         mem_rd;
    logic         mem_wr;
    bus_data_t    mem_rddata;

    periph_addr_t gpio_address;
    bus_data_t    gpio_wrdata;
    byte_en_t     gpio_byteenable;
    logic         gpio_rd;
    logic         gpio_wr;
    bus_data_t    gpio_rddata;

    periph_addr_t ticker_address;
    bus_data_t    ticker_wrdata;
    logic         ticker_rd;
    logic         ticker_wr;
    bus_data_t    ticker_rddata;

    dbus DBUS (
        .clk                 (clk),
        .reset_i             (reset_i),
        .master_address_i    (dbus_address_i),
        .master_byteenable_i (dbus_byteenable_i),
        .master_read_i       (dbus_read_i),
        .master_write_i      (dbus_write_i),
        .master_wrdata_i     (dbus_wrdata_i),
        .master_rddata_o     (dbus_rddata_o),
        .master_stall_o      (dbus_stall_o),
        .ram_address_o       (ram_address),
        .ram_wrdata_o        (ram_wrdata),
        .ram_byteenable_o    (ram_byteenable),
        .ram_rd_o            (ram_rd),
        .ram_wr_o            (ram_wr),
        .ram_rddata_i        (ram_rddata),
        .ram_stall_i         (ram_stall),
        .gpio_address_o      (gpio_address),
        .gpio_wrdata_o       (gpio_wrdata),
        .gpio_byteenable_o   (gpio_byteenable),
        .gpio_rd_o           (gpio_rd),
        .gpio_wr_o           (gpio_wr),
        .gpio_rddata_i       (gpio_rddata),
        .ticker_address_o    (ticker_address),
        .ticker_wrdata_o     (ticker_wrdata),
        .ticker_rd_o         (ticker_rd),
        .ticker_wr_o         (ticker_wr),
        .ticker_rddata_i     (ticker_rddata)
    );

    bytes_conv MEM_CONV (
        .clk           (clk),
        .reset_i       (reset_i),
        .address_i     (ram_address),
        .byteenable_i  (ram_byteenable),
        .wrdata_i      (ram_wrdata),
        .read_i        (ram_rd),
        .write_i       (ram_wr),
        .rddata_o      (ram_rddata),
        .stall_o       (ram_stall),
        .mem_address_o (mem_address),
        .mem_wrdata_o  (mem_wrdata),
        .mem_rd_o      (mem_rd),
        .mem_wr_o      (mem_wr),
        .mem_rddata_i  (mem_rddata)
    );

    word_ram MAINRAM (
        .clk       (clk),
        .address_i (mem_address),
        .wrdata_i  (mem_wrdata),
        .rd_i      (mem_rd),
        .wr_i      (mem_wr),
        .rddata_o  (mem_rddata)
    );

    gpio_top GPIO (
        .clk          (clk),
        .reset_i      (reset_i),
        .address_i    (gpio_address),
        .wrdata_i     (gpio_wrdata),
        .byteenable_i (gpio_byteenable),
        .rd_i         (gpio_rd),
        .wr_i         (gpio_wr),
        .rddata_o     (gpio_rddata),
        .gpio_i       (gpio_i),
        .gpio_o       (gpio_o)
    );

    ticker TICKER (
        .clk       (clk),
        .reset_i   (reset_i),
        .address_i (ticker_address),
        .wrdata_i  (ticker_wrdata),
        .rd_i      (ticker_rd),
        .wr_i      (ticker_wr),
        .rddata_o  (ticker_rddata),
        .irq_o     (ticker_irq_o)
    );

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

    // data bus widths
    typedef logic [31:0] bus_addr_t;                // byte address.
    typedef logic [31:0] bus_data_t;                // one data word.
    typedef logic [3:0]  byte_en_t;                 // bit n enables byte n.

    localparam int RAM_AW = 10;                     // 1024 words of main ram.

    typedef logic [RAM_AW-1:0] ram_addr_t;          // ram word address.

    // region codes held in address bits 31:28
    localparam logic [3:0] REGION_RAM    = 4'h0;
    localparam logic [3:0] REGION_GPIO   = 4'h8;
    localparam logic [3:0] REGION_TICKER = 4'h9;

    typedef logic [7:0] periph_addr_t;              // register offset, address bits 9:2.

    // byte converter sequence for partial ram writes
    typedef enum logic [1:0] {
        IDLE,                                       // pass-through.
        MERGE_READ,                                 // old word returning, merged word written.
        MERGE_WRITE                                 // write done, request accepted.
    } conv_state_t;

endpackage

// File: rtl/ticker.sv
`timescale 1ns/10ps

module ticker import soc_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  periph_addr_t address_i,
    input  bus_data_t    wrdata_i,
    input  logic         rd_i,
    input  logic         wr_i,
    output bus_data_t    rddata_o,
    output logic         irq_o
);

    bus_data_t count_q;
    bus_data_t compare_q;
    logic      cmp_wr;
    logic      irq_q;

    assign cmp_wr = wr_i && (address_i == 'd1);
    assign irq_o  = irq_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;              // free running and wrapping.
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            compare_q <= '0;
            irq_q     <= 1'b0;
        end else if (cmp_wr) begin
            compare_q <= wrdata_i;
            irq_q     <= 1'b0;                      // a new compare acknowledges.
        end else if (compare_q != '0 && count_q == compare_q) begin
            irq_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            case (address_i)
                'd0:     rddata_o <= count_q;       // count at the acceptance edge.
                'd1:     rddata_o <= compare_q;
                default: rddata_o <= '0;
            endcase
        end
    end

    a_no_irq_without_compare: assert property (@(posedge clk) disable iff (reset_i)
        (compare_q == '0) |-> !irq_o);

endmodule

// File: rtl/word_ram.sv
`timescale 1ns/10ps

module word_ram import soc_pkg::*; (
    input  logic      clk,
    input  ram_addr_t address_i,
    input  bus_data_t wrdata_i,
    input  logic      rd_i,
    input  logic      wr_i,
    output bus_data_t rddata_o
);

    bus_data_t mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[address_i] <= wrdata_i;
        end
    end

    // output holds until the next read.
    always_ff @(posedge clk) begin
        if (rd_i) begin
            rddata_o <= mem[address_i];
        end
    end

endmodule
